// ==== rtl/board_bus_defs.svh ====
`ifndef BOARD_BUS_DEFS_SVH
`define BOARD_BUS_DEFS_SVH

// bus data and address width
`define BUS_W 64

// word ram window
`define RAM_BASE  64'h0000_0000_0000_0000
`define RAM_WORDS 1024
`define RAM_BYTES (`RAM_WORDS * 4)

// keyboard ascii register
`define KEY_ADDR 64'h0000_0000_1000_0000

// sd card registers
`define SDC_ADDR_REG  64'h0000_0000_2000_0000
`define SDC_READ_REG  64'h0000_0000_2000_0008
`define SDC_READY_REG 64'h0000_0000_2000_0010
`define SDC_AVAIL_REG 64'h0000_0000_2000_0018

// sector buffer window
`define SDC_BUF_BASE  64'h0000_0000_3000_0000
`define SDC_BUF_BYTES 512

// available flag drops once capture gets this far into the next sector
`define SDC_CLEAR_INDEX 10

`endif

// ==== rtl/board_bus_pkg.sv ====
`default_nettype none

package board_bus_pkg;

    // access size codes as carried in the low two bits
    typedef enum logic [1:0] {
        SZ_BYTE   = 2'd0,
        SZ_HALF   = 2'd1,
        SZ_WORD   = 2'd2,
        SZ_DOUBLE = 2'd3
    } access_size_e;

    typedef struct packed {
        logic         is_unsigned; // lbu lhu lwu
        access_size_e size;
    } access_fields_t;

    // same 3 bits seen as the raw bus code or as split fields
    typedef union packed {
        logic [2:0]     raw;
        access_fields_t f;
    } access_type_u;

endpackage

`default_nettype wire

// ==== rtl/bus_control.sv ====
`timescale 1ns/10ps
`default_nettype none
`include "board_bus_defs.svh"

module bus_control (
    input  wire                                 CLOCK_50,
    input  wire                                 KEY0,
    input  wire [`BUS_W-1:0]                    bus_address,
    input  wire                                 bus_read_enable,
    input  wire                                 bus_write_enable,
    input  wire board_bus_pkg::access_type_u    bus_read_type,
    input  wire [7:0]                           key_ascii,
    input  wire                                 sd_ready,
    input  wire [`BUS_W-1:0]                    ram_rdata,
    input  wire                                 ram_finish,
    input  wire [7:0]                           sd_buf_byte,
    input  wire                                 sd_available,
    output logic [`BUS_W-1:0]                   bus_read_data,
    output logic                                bus_read_done,
    output logic                                bus_write_done,
    output logic                                ram_read_pend,
    output logic                                ram_write_pend,
    output logic [$clog2(`SDC_BUF_BYTES)-1:0]   sd_buf_index,
    output logic                                sd_addr_write,
    output logic                                sd_read_write
);

    logic ram_sel, key_sel, addr_sel, rd_reg_sel, ready_sel, avail_sel, buf_sel;
    logic [`BUS_W-1:0] buf_off;
    logic              read_hit;
    logic              write_hit;
    logic              rd_double;
    logic [`BUS_W-1:0] rd_mux;

    // address map decode
    assign ram_sel    = (bus_address >= `RAM_BASE) && (bus_address < `RAM_BASE + `RAM_BYTES);
    assign key_sel    = (bus_address == `KEY_ADDR);
    assign addr_sel   = (bus_address == `SDC_ADDR_REG);
    assign rd_reg_sel = (bus_address == `SDC_READ_REG);
    assign ready_sel  = (bus_address == `SDC_READY_REG);
    assign avail_sel  = (bus_address == `SDC_AVAIL_REG);
    assign buf_sel    = (bus_address >= `SDC_BUF_BASE) &&
                        (bus_address < `SDC_BUF_BASE + `SDC_BUF_BYTES);

    assign buf_off      = bus_address - `SDC_BUF_BASE;
    assign sd_buf_index = buf_off[$clog2(`SDC_BUF_BYTES)-1:0]; // byte offset in sector

    // ram sees the strobe cycle too so it can start straight away
    assign ram_read_pend  = ram_sel && (bus_read_enable || !bus_read_done);
    assign ram_write_pend = ram_sel && (bus_write_enable || !bus_write_done);

    // register writes take effect on the completing edge
    assign sd_addr_write = addr_sel && !bus_write_done;
    assign sd_read_write = rd_reg_sel && !bus_write_done;

    // unmapped addresses hit nothing and hang
    assign read_hit  = key_sel || ready_sel || avail_sel || buf_sel || (ram_sel && ram_finish);
    assign write_hit = key_sel || addr_sel || rd_reg_sel || ready_sel || avail_sel || buf_sel ||
                       (ram_sel && ram_finish);

    // unsigned bit is ignored here, sub-double loads are always zero-extended
    assign rd_double = (bus_read_type.f.size == board_bus_pkg::SZ_DOUBLE);

    always_comb begin
        if (key_sel)
            rd_mux = {{(`BUS_W-8){1'b0}}, key_ascii};
        else if (ready_sel)
            rd_mux = {{(`BUS_W-1){1'b0}}, sd_ready};
        else if (avail_sel)
            rd_mux = {{(`BUS_W-1){1'b0}}, sd_available};
        else if (buf_sel)
            rd_mux = {{(`BUS_W-8){1'b0}}, sd_buf_byte}; // one byte whatever the size
        else if (rd_double)
            rd_mux = ram_rdata;                         // both beats
        else
            rd_mux = {32'd0, ram_rdata[31:0]};          // shifted word
    end

    // done levels idle high
    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            bus_read_done  <= 1'b1;
            bus_write_done <= 1'b1;
        end else begin
            if (bus_read_enable)
                bus_read_done <= 1'b0;
            else if (!bus_read_done && read_hit)
                bus_read_done <= 1'b1;
            if (bus_write_enable)
                bus_write_done <= 1'b0;
            else if (!bus_write_done && write_hit)
                bus_write_done <= 1'b1;
        end
    end

    always_ff @(posedge CLOCK_50) begin
        if (!bus_read_done && read_hit)
            bus_read_data <= rd_mux; // valid as done rises
    end

endmodule

`default_nettype wire

// ==== rtl/word_ram.sv ====
`timescale 1ns/10ps
`default_nettype none
`include "board_bus_defs.svh"

module word_ram (
    input  wire                              CLOCK_50,
    input  wire                              KEY0,
    input  wire [`BUS_W-1:0]                 bus_address,
    input  wire [`BUS_W-1:0]                 bus_write_data,
    input  wire board_bus_pkg::access_type_u bus_read_type,
    input  wire board_bus_pkg::access_type_u bus_write_type,
    input  wire                              ram_read_pend,
    input  wire                              ram_write_pend,
    output logic [`BUS_W-1:0]                ram_rdata,
    output logic                             ram_finish
);

    localparam int AW = $clog2(`RAM_WORDS);

    logic [31:0]       mem [0:`RAM_WORDS-1];
    logic [`BUS_W-1:0] ram_off;
    logic [AW-1:0]     idx;
    logic [1:0]        off;
    logic              beat;       // second half of a double
    logic              active;
    logic              is_double;
    logic              we;
    logic              re;
    logic [3:0]        wr_be;
    logic [31:0]       wr_word;
    board_bus_pkg::access_type_u cur_type;

    assign ram_off = bus_address - `RAM_BASE;
    assign off     = ram_off[1:0];
    assign idx     = ram_off[AW+1:2] + {{(AW-1){1'b0}}, beat}; // next word on beat 1

    // hold off once finish is up until the master drops pend
    assign active    = (ram_read_pend || ram_write_pend) && !ram_finish;
    assign cur_type  = ram_write_pend ? bus_write_type : bus_read_type;
    assign is_double = (cur_type.f.size == board_bus_pkg::SZ_DOUBLE);
    assign we        = active && ram_write_pend;
    assign re        = active && ram_read_pend && !ram_write_pend;

    // lane enables and replicated store data, little-endian
    always_comb begin
        wr_be   = 4'b1111;
        wr_word = bus_write_data[31:0];
        case (bus_write_type.f.size)
            board_bus_pkg::SZ_BYTE: begin
                wr_be   = 4'b0001 << off;
                wr_word = {4{bus_write_data[7:0]}};
            end
            board_bus_pkg::SZ_HALF: begin
                wr_be   = off[1] ? 4'b1100 : 4'b0011; // bit 1 picks the half
                wr_word = {2{bus_write_data[15:0]}};
            end
            board_bus_pkg::SZ_DOUBLE:
                wr_word = beat ? bus_write_data[63:32] : bus_write_data[31:0];
            default: ;
        endcase
    end

    always_ff @(posedge CLOCK_50) begin
        for (int b = 0; b < 4; b++) begin
            if (we && wr_be[b])
                mem[idx][8*b +: 8] <= wr_word[8*b +: 8];
        end
        if (re) begin
            if (!is_double)
                ram_rdata <= {32'd0, mem[idx] >> (8 * off)};
            else if (beat)
                ram_rdata[63:32] <= mem[idx]; // high word
            else
                ram_rdata[31:0] <= mem[idx];  // low word first
        end
    end

    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            beat       <= 1'b0;
            ram_finish <= 1'b0;
        end else begin
            ram_finish <= active && (!is_double || beat);
            if (active && is_double)
                beat <= !beat;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/sd_sector_buffer.sv ====
`timescale 1ns/10ps
`default_nettype none
`include "board_bus_defs.svh"

module sd_sector_buffer (
    input  wire                                CLOCK_50,
    input  wire                                KEY0,
    input  wire [7:0]                          sd_dout,
    input  wire                                sd_byte_available,
    input  wire [$clog2(`SDC_BUF_BYTES)-1:0]   sd_buf_index,
    input  wire                                sd_addr_write,
    input  wire                                sd_read_write,
    input  wire [`BUS_W-1:0]                   bus_write_data,
    output logic [7:0]                         sd_buf_byte,
    output logic                               sd_available,
    output logic [31:0]                        sd_addr,
    output logic                               sd_rd_start
);

    localparam int IW = $clog2(`SDC_BUF_BYTES);

    logic [7:0]  sector [0:`SDC_BUF_BYTES-1];
    logic [IW:0] byte_index;   // one extra bit to reach 512
    logic        byte_avail_d;
    logic        byte_rise;
    logic        wrap;
    logic [IW:0] wr_slot;

    assign byte_rise = sd_byte_available && !byte_avail_d;
    assign wrap      = (byte_index == `SDC_BUF_BYTES);
    assign wr_slot   = wrap ? '0 : byte_index; // byte landing on the wrap goes to 0

    always_ff @(posedge CLOCK_50) begin
        if (byte_rise)
            sector[wr_slot[IW-1:0]] <= sd_dout;
        sd_buf_byte <= sector[sd_buf_index]; // ready by the completing edge
    end

    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            byte_index   <= '0;
            byte_avail_d <= 1'b0;
            sd_available <= 1'b0;
            sd_addr      <= 32'd0;
            sd_rd_start  <= 1'b0;
        end else begin
            byte_avail_d <= sd_byte_available;
            if (byte_rise)
                byte_index <= wr_slot + 1'b1;
            else if (wrap)
                byte_index <= '0;
            if (wrap)
                sd_available <= 1'b1; // whole sector in
            else if (byte_index == `SDC_CLEAR_INDEX)
                sd_available <= 1'b0;
            if (sd_addr_write)
                sd_addr <= bus_write_data[31:0];
            sd_rd_start <= sd_read_write; // single cycle, write done follows
        end
    end

endmodule

`default_nettype wire

// ==== rtl/key_interrupt.sv ====
`timescale 1ns/10ps
`default_nettype none

module key_interrupt (
    input  wire        CLOCK_50,
    input  wire        KEY0,
    input  wire [7:0]  key_ascii,
    input  wire        key_pressed,
    input  wire        irq_ack,
    output logic [3:0] irq_vector,
    output logic       irq_led
);

    logic key_irq; // press with a real code

    assign key_irq = key_pressed && (key_ascii != 8'd0);

    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            irq_vector <= 4'd0;
            irq_led    <= 1'b0;
        end else if (irq_ack) begin
            irq_vector <= 4'd0; // ack beats a new press
            irq_led    <= 1'b0;
        end else if (key_irq) begin
            irq_vector <= 4'd1; // keyboard vector
            irq_led    <= 1'b1;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/board_bus_top.sv ====
`timescale 1ns/10ps
`default_nettype none
`include "board_bus_defs.svh"

module board_bus_top (
    input  wire                              CLOCK_50,
    input  wire                              KEY0,
    input  wire [`BUS_W-1:0]                 bus_address,
    input  wire [`BUS_W-1:0]                 bus_write_data,
    input  wire                              bus_read_enable,
    input  wire                              bus_write_enable,
    input  wire board_bus_pkg::access_type_u bus_read_type,
    input  wire board_bus_pkg::access_type_u bus_write_type,
    input  wire [7:0]                        key_ascii,
    input  wire                              key_pressed,
    input  wire                              irq_ack,
    input  wire [7:0]                        sd_dout,
    input  wire                              sd_byte_available,
    input  wire                              sd_ready,
    output wire [`BUS_W-1:0]                 bus_read_data,
    output wire                              bus_read_done,
    output wire                              bus_write_done,
    output wire [3:0]                        irq_vector,
    output wire                              irq_led,
    output wire [31:0]                       sd_addr,
    output wire                              sd_rd_start
);

    wire [`BUS_W-1:0]                 ram_rdata;
    wire                              ram_finish;
    wire                              ram_read_pend;
    wire                              ram_write_pend;
    wire [$clog2(`SDC_BUF_BYTES)-1:0] sd_buf_index;
    wire                              sd_addr_write;
    wire                              sd_read_write;
    wire [7:0]                        sd_buf_byte;
    wire                              sd_available;

    bus_control u_bus_control (
        .CLOCK_50, .KEY0, .bus_address, .bus_read_enable, .bus_write_enable,
        .bus_read_type, .key_ascii, .sd_ready, .ram_rdata, .ram_finish,
        .sd_buf_byte, .sd_available, .bus_read_data, .bus_read_done,
        .bus_write_done, .ram_read_pend, .ram_write_pend, .sd_buf_index,
        .sd_addr_write, .sd_read_write
    );

    word_ram u_word_ram (
        .CLOCK_50, .KEY0, .bus_address, .bus_write_data, .bus_read_type,
        .bus_write_type, .ram_read_pend, .ram_write_pend, .ram_rdata, .ram_finish
    );

    // sector capture fed straight from the sd controller pins
    sd_sector_buffer u_sd_sector_buffer (
        .CLOCK_50, .KEY0, .sd_dout, .sd_byte_available, .sd_buf_index,
        .sd_addr_write, .sd_read_write, .bus_write_data, .sd_buf_byte,
        .sd_available, .sd_addr, .sd_rd_start
    );

    key_interrupt u_key_interrupt (
        .CLOCK_50, .KEY0, .key_ascii, .key_pressed, .irq_ack, .irq_vector, .irq_led
    );

endmodule

`default_nettype wire

// ==== verif/clock_gen.sv ====
`timescale 1ns/10ps
`default_nettype none

module clock_gen #(
    parameter real HALF_NS      = 4.0,
    parameter int  RESET_CYCLES = 8
) (
    output logic CLOCK_50,
    output logic KEY0
);

    initial begin
        CLOCK_50 = 1'b0;
        forever #(HALF_NS) CLOCK_50 = ~CLOCK_50; // 8 ns period
    end

    // reset low for a fixed count, let go on a falling edge
    initial begin
        KEY0 = 1'b0;
        repeat (RESET_CYCLES) @(posedge CLOCK_50);
        @(negedge CLOCK_50);
        KEY0 = 1'b1;
    end

endmodule

`default_nettype wire

// ==== verif/tb_board_bus.sv ====
`timescale 1ns/10ps
`default_nettype none
`include "board_bus_defs.svh"

module tb_board_bus;

    localparam int TIMEOUT = 200; // cycles per wait
    localparam board_bus_pkg::access_type_u WORD_T = 3'b010;

    wire                         CLOCK_50;
    wire                         KEY0;
    logic [`BUS_W-1:0]           bus_address;
    logic [`BUS_W-1:0]           bus_write_data;
    logic                        bus_read_enable;
    logic                        bus_write_enable;
    board_bus_pkg::access_type_u bus_read_type;
    board_bus_pkg::access_type_u bus_write_type;
    logic [7:0]                  key_ascii;
    logic                        key_pressed;
    logic                        irq_ack;
    logic [7:0]                  sd_dout;
    logic                        sd_byte_available;
    logic                        sd_ready;
    wire [`BUS_W-1:0]            bus_read_data;
    wire                         bus_read_done;
    wire                         bus_write_done;
    wire [3:0]                   irq_vector;
    wire                         irq_led;
    wire [31:0]                  sd_addr;
    wire                         sd_rd_start;

    logic [31:0] ram_model [0:`RAM_WORDS-1];     // reference word store
    logic [7:0]  buf_model [0:`SDC_BUF_BYTES-1]; // bytes fed to the sector
    logic [31:0] rng = 32'd18;
    int          start_pulses = 0;

    clock_gen clk_gen0 (.CLOCK_50, .KEY0);

    board_bus_top dut0 (.*);

    // count read-start pulses away from the rising edge
    always @(negedge CLOCK_50) begin
        if (sd_rd_start === 1'b1)
            start_pulses++;
    end

    function automatic logic [31:0] next_rand();
        rng = rng * 32'd1664525 + 32'd1013904223;
        return {rng[15:0], rng[31:16]}; // swap halves so the strong high bits come out low
    endfunction

    task automatic tick();
        @(posedge CLOCK_50);
        #1; // drive and sample just after the edge
    endtask

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("Simulation finished: FAIL");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic check_data(input logic [63:0] got, input logic [63:0] exp, input string what);
        if (got !== exp)
            abort_run($sformatf("MISMATCH at %0t ns: %s got %h expected %h",
                                $time, what, got, exp));
    endtask

    task automatic check_type(input board_bus_pkg::access_type_u t, input logic [63:0] addr,
                              input logic [63:0] got, input logic [63:0] exp);
        if (got !== exp)
            abort_run($sformatf(
                "MISMATCH at %0t ns: load size %0d unsigned %0b at %h got %h expected %h",
                $time, t.f.size, t.f.is_unsigned, addr, got, exp));
    endtask

    task automatic check_irq(input logic [3:0] exp_vec, input logic exp_led, input string what);
        if (irq_vector !== exp_vec || irq_led !== exp_led)
            abort_run($sformatf("MISMATCH at %0t ns: %s irq %h led %b expected %h led %b",
                                $time, what, irq_vector, irq_led, exp_vec, exp_led));
    endtask

    task automatic wait_done(input bit is_read);
        int n;
        n = 0;
        while ((is_read ? bus_read_done : bus_write_done) !== 1'b1) begin
            if (n == TIMEOUT)
                abort_run($sformatf("bus %s done never came back at %0t ns",
                                    is_read ? "read" : "write", $time));
            tick();
            n++;
        end
    endtask

    task automatic bus_read(input logic [63:0] addr, input board_bus_pkg::access_type_u t,
                            output logic [63:0] data);
        bus_address     = addr;
        bus_read_type   = t;
        bus_read_enable = 1'b1; // one cycle strobe
        tick();
        bus_read_enable = 1'b0;
        check_data({63'd0, bus_read_done}, 64'd0, "read done after strobe");
        wait_done(1'b1);
        data = bus_read_data;
    endtask

    task automatic bus_write(input logic [63:0] addr, input board_bus_pkg::access_type_u t,
                             input logic [63:0] data);
        bus_address      = addr;
        bus_write_type   = t;
        bus_write_data   = data;
        bus_write_enable = 1'b1;
        tick();
        bus_write_enable = 1'b0;
        check_data({63'd0, bus_write_done}, 64'd0, "write done after strobe");
        wait_done(1'b0);
    endtask

    task automatic feed_byte(input logic [7:0] b);
        sd_dout           = b;
        sd_byte_available = 1'b1; // rising edge captures
        tick();
        sd_byte_available = 1'b0;
        tick();
    endtask

    // little-endian lanes with word index at address over four
    function automatic void model_store(logic [63:0] addr, board_bus_pkg::access_type_u t,
                                        logic [63:0] data);
        int i;
        int o;
        i = int'((addr - `RAM_BASE) >> 2);
        o = int'(addr[1:0]);
        case (t.f.size)
            board_bus_pkg::SZ_BYTE: ram_model[i][8*o +: 8] = data[7:0];
            board_bus_pkg::SZ_HALF: ram_model[i][(addr[1] ? 16 : 0) +: 16] = data[15:0];
            board_bus_pkg::SZ_WORD: ram_model[i] = data[31:0];
            default: begin
                ram_model[i] = data[31:0];                     // low word first
                ram_model[(i + 1) % `RAM_WORDS] = data[63:32];
            end
        endcase
    endfunction

    function automatic logic [63:0] model_load(logic [63:0] addr, board_bus_pkg::access_type_u t);
        int i;
        i = int'((addr - `RAM_BASE) >> 2);
        if (t.f.size == board_bus_pkg::SZ_DOUBLE)
            return {ram_model[(i + 1) % `RAM_WORDS], ram_model[i]};
        return {32'd0, ram_model[i] >> (8 * addr[1:0])}; // zero-extended whatever the unsigned bit
    endfunction

    initial begin
        logic [63:0] addr;
        logic [63:0] data;
        logic [63:0] got;
        logic [31:0] r;
        board_bus_pkg::access_type_u t;
        int n;
        bus_address       = '0;
        bus_write_data    = '0;
        bus_read_enable   = 1'b0;
        bus_write_enable  = 1'b0;
        bus_read_type     = WORD_T;
        bus_write_type    = WORD_T;
        key_ascii         = 8'd0;
        key_pressed       = 1'b0;
        irq_ack           = 1'b0;
        sd_dout           = 8'd0;
        sd_byte_available = 1'b0;
        sd_ready          = 1'b0;
        n = 0;
        while (KEY0 !== 1'b1) begin
            if (n == TIMEOUT)
                abort_run("reset was never released");
            tick();
            n++;
        end
        tick();

        // idle state out of reset
        check_data({62'd0, bus_read_done, bus_write_done}, 64'd3, "done levels after reset");
        check_irq(4'd0, 1'b0, "after reset");
        check_data({63'd0, sd_rd_start}, 64'd0, "read start after reset");
        check_data({32'd0, sd_addr}, 64'd0, "sector address after reset");

        // distinct fill word per address
        for (int i = 0; i < `RAM_WORDS; i++) begin
            addr = `RAM_BASE + 64'(4 * i);
            data = {32'd0, 32'hC3A5_0000 ^ (32'(i) * 32'h0001_0003)};
            bus_write(addr, WORD_T, data);
            model_store(addr, WORD_T, data);
        end

        // random stores of all sizes in a 128 word window
        for (int k = 0; k < 300; k++) begin
            r     = next_rand();
            addr  = `RAM_BASE + {55'd0, r[8:0]};
            t.raw = r[11:9];
            data  = {next_rand(), next_rand()};
            bus_write(addr, t, data);
            model_store(addr, t, data);
            r     = next_rand();
            t.raw = r[2:0];
            bus_read(addr, t, got);
            check_type(t, addr, got, model_load(addr, t));
            if (r[3]) begin
                addr  = `RAM_BASE + {55'd0, r[16:8]}; // somewhere else
                t.raw = r[6:4];
                bus_read(addr, t, got);
                check_type(t, addr, got, model_load(addr, t));
            end
        end

        // keyboard register and interrupt
        r         = next_rand();
        key_ascii = r[7:0] | 8'h01;
        bus_read(`KEY_ADDR, WORD_T, got);
        check_data(got, {56'd0, key_ascii}, "keyboard register");
        key_pressed = 1'b1;
        tick();
        key_pressed = 1'b0;
        check_irq(4'd1, 1'b1, "key press");
        irq_ack = 1'b1;
        tick();
        irq_ack = 1'b0;
        check_irq(4'd0, 1'b0, "acknowledge");
        key_pressed = 1'b1;
        irq_ack     = 1'b1; // ack wins over a press in the same cycle
        tick();
        key_pressed = 1'b0;
        irq_ack     = 1'b0;
        check_irq(4'd0, 1'b0, "press with ack");
        key_ascii   = 8'd0;
        key_pressed = 1'b1;
        tick();
        key_pressed = 1'b0;
        check_irq(4'd0, 1'b0, "press with zero code");

        // one full sector
        for (int j = 0; j < `SDC_BUF_BYTES; j++) begin
            if (j == `SDC_BUF_BYTES - 1) begin
                bus_read(`SDC_AVAIL_REG, WORD_T, got);
                check_data(got, 64'd0, "available before last byte");
            end
            r = next_rand();
            buf_model[j] = r[7:0];
            feed_byte(r[7:0]);
        end
        bus_read(`SDC_AVAIL_REG, WORD_T, got);
        check_data(got, 64'd1, "available after full sector");
        for (int k = 0; k < 40; k++) begin
            r = next_rand();
            t.raw = r[11:9];
            bus_read(`SDC_BUF_BASE + {55'd0, r[8:0]}, t, got);
            check_data(got, {56'd0, buf_model[r[8:0]]}, "sector buffer byte");
        end
        for (int j = 0; j < `SDC_CLEAR_INDEX; j++) begin
            if (j == `SDC_CLEAR_INDEX - 1) begin
                bus_read(`SDC_AVAIL_REG, WORD_T, got);
                check_data(got, 64'd1, "available before clear index");
            end
            r = next_rand();
            buf_model[j] = r[7:0];
            feed_byte(r[7:0]);
        end
        bus_read(`SDC_AVAIL_REG, WORD_T, got);
        check_data(got, 64'd0, "available after ten more bytes");
        bus_read(`SDC_BUF_BASE + 64'd9, WORD_T, got);
        check_data(got, {56'd0, buf_model[9]}, "overwritten buffer byte");

        // sector address, read start, ready flag
        data = {next_rand(), next_rand()};
        bus_write(`SDC_ADDR_REG, WORD_T, data);
        check_data({32'd0, sd_addr}, {32'd0, data[31:0]}, "sector address");
        check_data(64'(start_pulses), 64'd0, "read start before write");
        bus_write(`SDC_READ_REG, WORD_T, data);
        repeat (4) tick();
        check_data(64'(start_pulses), 64'd1, "read start pulse count");
        sd_ready = 1'b1;
        bus_read(`SDC_READY_REG, WORD_T, got);
        check_data(got, 64'd1, "ready flag high");
        sd_ready = 1'b0;
        bus_read(`SDC_READY_REG, WORD_T, got);
        check_data(got, 64'd0, "ready flag low");

        $display("Simulation finished: PASS");
        $finish;
    end

endmodule

`default_nettype wire

// ==== board_bus.f ====
+incdir+rtl
rtl/board_bus_pkg.sv
rtl/bus_control.sv
rtl/word_ram.sv
rtl/sd_sector_buffer.sv
rtl/key_interrupt.sv
rtl/board_bus_top.sv
verif/clock_gen.sv
verif/tb_board_bus.sv

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing -Wno-fatal -f board_bus.f --top-module tb_board_bus -Mdir obj_dir
./obj_dir/Vtb_board_bus | tee sim.log
if grep -q "Simulation finished: PASS" sim.log; then
    echo "run_sim: passed"
else
    echo "run_sim: failed"
    exit 1
fi
